/* logic/dmem_pkg.sv */
//----------------------------------------
// Shared types of the data-memory subsystem:
// request handshake enums and struct, AHB-Lite
// bus structs and timer register offsets
//----------------------------------------

package dmem_pkg;

    parameter int unsigned XLEN = 32;

    //----------------------------------------
    // Requester handshake
    //----------------------------------------
    typedef enum logic {
        MEM_CMD_RD,
        MEM_CMD_WR
    } mem_cmd_e;

    typedef enum logic [1:0] {
        MEM_WIDTH_BYTE,
        MEM_WIDTH_HWORD,
        MEM_WIDTH_WORD
    } mem_width_e;

    typedef enum logic [1:0] {
        MEM_RESP_IDLE,
        MEM_RESP_RDY_OK,
        MEM_RESP_RDY_ER
    } mem_resp_e;

    typedef struct packed {
        mem_cmd_e           cmd;
        mem_width_e         width;
        logic [XLEN-1:0]    addr;
        logic [XLEN-1:0]    wdata;      // Byte lanes follow the address
    } mem_req_t;

    //----------------------------------------
    // AHB-Lite master side
    //----------------------------------------
    typedef enum logic [1:0] {
        HTRANS_IDLE   = 2'b00,
        HTRANS_NONSEQ = 2'b10
    } htrans_e;

    typedef struct packed {
        logic [XLEN-1:0]    haddr;
        htrans_e            htrans;
        logic [2:0]         hsize;
        logic               hwrite;
        logic [XLEN-1:0]    hwdata;
        logic [3:0]         hprot;
        logic [2:0]         hburst;
        logic               hmastlock;
    } ahb_m2s_t;

    typedef struct packed {
        logic               hready;
        logic               hresp;      // Error response from the slave
        logic [XLEN-1:0]    hrdata;
    } ahb_s2m_t;

    // Timer registers, byte offsets in the timer window
    parameter logic [4:0] TMR_CTRL     = 5'd0;
    parameter logic [4:0] TMR_MTIME_LO = 5'd4;
    parameter logic [4:0] TMR_MTIME_HI = 5'd8;
    parameter logic [4:0] TMR_CMP_LO   = 5'd12;
    parameter logic [4:0] TMR_CMP_HI   = 5'd16;

endpackage : dmem_pkg

/* logic/dmem_router.sv */
//----------------------------------------
// Data-memory router: address decode, steering
// to TCM, timer and AHB ports, response return
//----------------------------------------

module dmem_router #(
    parameter logic [dmem_pkg::XLEN-1:0] TCM_ADDR_MASK      = 32'hFFFF_0000,
    parameter logic [dmem_pkg::XLEN-1:0] TCM_ADDR_PATTERN   = 32'h0000_0000,
    parameter logic [dmem_pkg::XLEN-1:0] TIMER_ADDR_MASK    = 32'hFFFF_FFE0,
    parameter logic [dmem_pkg::XLEN-1:0] TIMER_ADDR_PATTERN = 32'h0049_0000
) (
    input  logic                        clk,
    input  logic                        rst_i,
    // Upstream requester
    input  logic                        req_i,
    input  dmem_pkg::mem_req_t          req_data_i,
    output logic                        req_ack_o,
    output dmem_pkg::mem_resp_e         resp_o,
    output logic [dmem_pkg::XLEN-1:0]   rdata_o,
    // TCM port
    output logic                        tcm_req_o,
    output dmem_pkg::mem_req_t          tcm_data_o,
    input  logic                        tcm_ack_i,
    input  dmem_pkg::mem_resp_e         tcm_resp_i,
    input  logic [dmem_pkg::XLEN-1:0]   tcm_rdata_i,
    // Timer port
    output logic                        tmr_req_o,
    output dmem_pkg::mem_req_t          tmr_data_o,
    input  logic                        tmr_ack_i,
    input  dmem_pkg::mem_resp_e         tmr_resp_i,
    input  logic [dmem_pkg::XLEN-1:0]   tmr_rdata_i,
    // AHB bridge port
    output logic                        ahb_req_o,
    output dmem_pkg::mem_req_t          ahb_data_o,
    input  logic                        ahb_ack_i,
    input  dmem_pkg::mem_resp_e         ahb_resp_i,
    input  logic [dmem_pkg::XLEN-1:0]   ahb_rdata_i
);
    import dmem_pkg::*;

    typedef enum logic [1:0] {
        ROUTE_TCM,
        ROUTE_TMR,
        ROUTE_AHB
    } route_e;

    route_e             route_sel;      // Target of the incoming request
    route_e             route_q;        // Target of the outstanding request
    logic               busy_q;
    logic               issue_ok;
    logic               sel_ack;
    mem_resp_e          cur_resp;
    logic [XLEN-1:0]    cur_rdata;
    mem_resp_e          resp_q;
    logic [XLEN-1:0]    rdata_q;

    // Anything outside both windows goes to AHB
    always_comb begin
        if ((req_data_i.addr & TCM_ADDR_MASK) == TCM_ADDR_PATTERN) begin
            route_sel = ROUTE_TCM;
        end else if ((req_data_i.addr & TIMER_ADDR_MASK) == TIMER_ADDR_PATTERN) begin
            route_sel = ROUTE_TMR;
        end else begin
            route_sel = ROUTE_AHB;
        end
    end

    always_comb begin
        case (route_sel)
            ROUTE_TCM: sel_ack = tcm_ack_i;
            ROUTE_TMR: sel_ack = tmr_ack_i;
            default:   sel_ack = ahb_ack_i;
        endcase
    end

    // Response select follows the registered route
    always_comb begin
        case (route_q)
            ROUTE_TCM: begin
                cur_resp  = tcm_resp_i;
                cur_rdata = tcm_rdata_i;
            end
            ROUTE_TMR: begin
                cur_resp  = tmr_resp_i;
                cur_rdata = tmr_rdata_i;
            end
            default: begin
                cur_resp  = ahb_resp_i;
                cur_rdata = ahb_rdata_i;
            end
        endcase
    end

    // Free, or the outstanding access ends this cycle
    assign issue_ok  = !busy_q || (cur_resp != MEM_RESP_IDLE);
    assign req_ack_o = issue_ok && sel_ack;

    assign tcm_req_o  = req_i && issue_ok && (route_sel == ROUTE_TCM);
    assign tmr_req_o  = req_i && issue_ok && (route_sel == ROUTE_TMR);
    assign ahb_req_o  = req_i && issue_ok && (route_sel == ROUTE_AHB);
    assign tcm_data_o = req_data_i;
    assign tmr_data_o = req_data_i;
    assign ahb_data_o = req_data_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            busy_q  <= 1'b0;
            route_q <= ROUTE_AHB;
            resp_q  <= MEM_RESP_IDLE;
        end else begin
            resp_q <= busy_q ? cur_resp : MEM_RESP_IDLE;
            if (req_i && req_ack_o) begin
                busy_q  <= 1'b1;
                route_q <= route_sel;
            end else if (cur_resp != MEM_RESP_IDLE) begin
                busy_q  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        rdata_q <= cur_rdata;
    end

    assign resp_o  = resp_q;
    assign rdata_o = rdata_q;

    a_single_resp: assert property (@(posedge clk) disable iff (rst_i)
        $onehot0({tcm_resp_i != MEM_RESP_IDLE, tmr_resp_i != MEM_RESP_IDLE,
                  ahb_resp_i != MEM_RESP_IDLE}))
        else $error("dmem_router: two targets responded in one cycle");

endmodule : dmem_router

/* logic/dmem_tcm.sv */
//----------------------------------------
// Tightly coupled data memory, one port,
// byte-lane writes
//----------------------------------------

module dmem_tcm #(
    parameter int unsigned TCM_WORDS = 1024
) (
    input  logic                        clk,
    input  logic                        rst_i,
    input  logic                        req_i,
    input  dmem_pkg::mem_req_t          req_data_i,
    output logic                        req_ack_o,
    output dmem_pkg::mem_resp_e         resp_o,
    output logic [dmem_pkg::XLEN-1:0]   rdata_o
);
    import dmem_pkg::*;

    localparam int unsigned IDX_W = $clog2(TCM_WORDS);

    logic [XLEN-1:0]    mem [TCM_WORDS];
    logic [IDX_W-1:0]   idx;
    logic [3:0]         be;             // Byte enables
    logic               misaligned;
    mem_resp_e          resp_q;
    logic [XLEN-1:0]    rdata_q;

    assign idx       = req_data_i.addr[IDX_W+1:2];
    assign req_ack_o = 1'b1;

    always_comb begin
        be         = 4'b0000;
        misaligned = 1'b0;
        case (req_data_i.width)
            MEM_WIDTH_BYTE:  be = 4'b0001 << req_data_i.addr[1:0];
            MEM_WIDTH_HWORD: begin
                be         = 4'b0011 << {req_data_i.addr[1], 1'b0};
                misaligned = req_data_i.addr[0];
            end
            MEM_WIDTH_WORD: begin
                be         = 4'b1111;
                misaligned = |req_data_i.addr[1:0];
            end
            default: misaligned = 1'b1;
        endcase
    end

    // Array access, misaligned requests leave it untouched
    always_ff @(posedge clk) begin
        if (req_i && !misaligned) begin
            if (req_data_i.cmd == MEM_CMD_WR) begin
                for (int i = 0; i < 4; i++) begin
                    if (be[i]) begin
                        mem[idx][8*i +: 8] <= req_data_i.wdata[8*i +: 8];
                    end
                end
            end else begin
                rdata_q <= mem[idx];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            resp_q <= MEM_RESP_IDLE;
        end else if (req_i) begin
            resp_q <= misaligned ? MEM_RESP_RDY_ER : MEM_RESP_RDY_OK;
        end else begin
            resp_q <= MEM_RESP_IDLE;
        end
    end

    assign resp_o  = resp_q;
    assign rdata_o = rdata_q;

endmodule : dmem_tcm

/* logic/mtimer.sv */
//----------------------------------------
// Memory-mapped 64-bit machine timer with
// compare register and interrupt
//----------------------------------------

module mtimer (
    input  logic                        clk,
    input  logic                        rst_i,
    input  logic                        req_i,
    input  dmem_pkg::mem_req_t          req_data_i,
    output logic                        req_ack_o,
    output dmem_pkg::mem_resp_e         resp_o,
    output logic [dmem_pkg::XLEN-1:0]   rdata_o,
    output logic                        timer_irq_o
);
    import dmem_pkg::*;

    logic [4:0]         offs;
    logic               acc_ok;         // Word access to a known register
    logic               wr_en;
    logic               en_q;           // Count enable, control bit 0
    logic [63:0]        mtime_q;
    logic [63:0]        cmp_q;
    logic [XLEN-1:0]    rd_val;
    mem_resp_e          resp_q;
    logic [XLEN-1:0]    rdata_q;
    logic               irq_q;

    assign offs      = req_data_i.addr[4:0];
    assign req_ack_o = 1'b1;

    //----------------------------------------
    // Register decode
    //----------------------------------------
    always_comb begin
        rd_val = '0;
        acc_ok = (req_data_i.width == MEM_WIDTH_WORD);
        case (offs)
            TMR_CTRL:     rd_val = {{(XLEN-1){1'b0}}, en_q};
            TMR_MTIME_LO: rd_val = mtime_q[31:0];
            TMR_MTIME_HI: rd_val = mtime_q[63:32];
            TMR_CMP_LO:   rd_val = cmp_q[31:0];
            TMR_CMP_HI:   rd_val = cmp_q[63:32];
            default:      acc_ok = 1'b0;
        endcase
    end

    assign wr_en = req_i && acc_ok && (req_data_i.cmd == MEM_CMD_WR);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            en_q    <= 1'b1;
            mtime_q <= '0;
            cmp_q   <= '1;              // Keeps the interrupt low out of reset
            irq_q   <= 1'b0;
        end else begin
            irq_q <= (mtime_q >= cmp_q);
            if (en_q) begin
                mtime_q <= mtime_q + 64'd1;
            end
            // A software write wins over the increment
            if (wr_en) begin
                case (offs)
                    TMR_CTRL:     en_q           <= req_data_i.wdata[0];
                    TMR_MTIME_LO: mtime_q[31:0]  <= req_data_i.wdata;
                    TMR_MTIME_HI: mtime_q[63:32] <= req_data_i.wdata;
                    TMR_CMP_LO:   cmp_q[31:0]    <= req_data_i.wdata;
                    TMR_CMP_HI:   cmp_q[63:32]   <= req_data_i.wdata;
                    default: ;
                endcase
            end
        end
    end

    //----------------------------------------
    // Response
    //----------------------------------------
    always_ff @(posedge clk) begin
        if (rst_i) begin
            resp_q <= MEM_RESP_IDLE;
        end else if (req_i) begin
            resp_q <= acc_ok ? MEM_RESP_RDY_OK : MEM_RESP_RDY_ER;
        end else begin
            resp_q <= MEM_RESP_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (req_i) begin
            rdata_q <= rd_val;
        end
    end

    assign resp_o      = resp_q;
    assign rdata_o     = rdata_q;
    assign timer_irq_o = irq_q;

endmodule : mtimer

/* logic/dmem_ahb_bridge.sv */
//----------------------------------------
// Request to AHB-Lite bridge, single transfers
// with address and data phases
//----------------------------------------

module dmem_ahb_bridge (
    input  logic                        clk,
    input  logic                        rst_i,
    input  logic                        req_i,
    input  dmem_pkg::mem_req_t          req_data_i,
    output logic                        req_ack_o,
    output dmem_pkg::mem_resp_e         resp_o,
    output logic [dmem_pkg::XLEN-1:0]   rdata_o,
    output dmem_pkg::ahb_m2s_t          ahb_o,
    input  dmem_pkg::ahb_s2m_t          ahb_i
);
    import dmem_pkg::*;

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_ADDR,
        PH_DATA
    } phase_e;

    localparam logic [2:0] HBURST_SINGLE = 3'b000;
    localparam logic [3:0] HPROT_DATA    = 4'b0001;

    phase_e             phase_q;
    mem_req_t           req_q;          // Transfer in flight
    logic               accept;
    logic               data_done;
    mem_resp_e          resp_q;
    logic [XLEN-1:0]    rdata_q;

    assign data_done = (phase_q == PH_DATA) && ahb_i.hready;
    assign req_ack_o = (phase_q == PH_IDLE) || data_done;
    assign accept    = req_i && req_ack_o;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            phase_q <= PH_IDLE;
            resp_q  <= MEM_RESP_IDLE;
        end else begin
            resp_q <= MEM_RESP_IDLE;
            if (data_done) begin
                resp_q <= ahb_i.hresp ? MEM_RESP_RDY_ER : MEM_RESP_RDY_OK;
            end
            case (phase_q)
                PH_IDLE: if (accept) phase_q <= PH_ADDR;
                PH_ADDR: if (ahb_i.hready) phase_q <= PH_DATA;
                PH_DATA: if (ahb_i.hready) phase_q <= accept ? PH_ADDR : PH_IDLE;
                default: phase_q <= PH_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req_data_i;
        end
        if (data_done) begin
            rdata_q <= ahb_i.hrdata;
        end
    end

    //----------------------------------------
    // Bus outputs
    //----------------------------------------
    always_comb begin
        ahb_o.haddr     = req_q.addr;
        ahb_o.hwrite    = (req_q.cmd == MEM_CMD_WR);
        ahb_o.hwdata    = req_q.wdata;  // Held through the data phase
        ahb_o.hprot     = HPROT_DATA;
        ahb_o.hburst    = HBURST_SINGLE;
        ahb_o.hmastlock = 1'b0;
        if (phase_q == PH_ADDR) begin
            ahb_o.htrans = HTRANS_NONSEQ;
        end else begin
            ahb_o.htrans = HTRANS_IDLE;
        end
        case (req_q.width)
            MEM_WIDTH_BYTE:  ahb_o.hsize = 3'b000;
            MEM_WIDTH_HWORD: ahb_o.hsize = 3'b001;
            default:         ahb_o.hsize = 3'b010;
        endcase
    end

    assign resp_o  = resp_q;
    assign rdata_o = rdata_q;

    a_addr_stable: assert property (@(posedge clk) disable iff (rst_i)
        (ahb_o.htrans == HTRANS_NONSEQ && !ahb_i.hready) |=>
            (ahb_o.htrans == HTRANS_NONSEQ) && $stable(ahb_o.haddr)
            && $stable(ahb_o.hsize) && $stable(ahb_o.hwrite))
        else $error("dmem_ahb_bridge: address phase changed under wait state");

endmodule : dmem_ahb_bridge

/* logic/dmem_subsys_top.sv */
//----------------------------------------
// Data-memory subsystem top: router, TCM,
// machine timer and AHB bridge
//----------------------------------------

module dmem_subsys_top #(
    parameter logic [dmem_pkg::XLEN-1:0] TCM_ADDR_MASK      = 32'hFFFF_0000,
    parameter logic [dmem_pkg::XLEN-1:0] TCM_ADDR_PATTERN   = 32'h0000_0000,
    parameter logic [dmem_pkg::XLEN-1:0] TIMER_ADDR_MASK    = 32'hFFFF_FFE0,
    parameter logic [dmem_pkg::XLEN-1:0] TIMER_ADDR_PATTERN = 32'h0049_0000,
    parameter int unsigned               TCM_WORDS          = 1024
) (
    input  logic                        clk,
    input  logic                        rst_i,
    input  logic                        req_i,
    input  dmem_pkg::mem_req_t          req_data_i,
    output logic                        req_ack_o,
    output dmem_pkg::mem_resp_e         resp_o,
    output logic [dmem_pkg::XLEN-1:0]   rdata_o,
    output dmem_pkg::ahb_m2s_t          ahb_o,
    input  dmem_pkg::ahb_s2m_t          ahb_i,
    output logic                        timer_irq_o
);
    import dmem_pkg::*;

    // Router to TCM
    logic               tcm_req;
    mem_req_t           tcm_data;
    logic               tcm_ack;
    mem_resp_e          tcm_resp;
    logic [XLEN-1:0]    tcm_rdata;
    // Router to timer
    logic               tmr_req;
    mem_req_t           tmr_data;
    logic               tmr_ack;
    mem_resp_e          tmr_resp;
    logic [XLEN-1:0]    tmr_rdata;
    // Router to AHB bridge
    logic               ahb_req;
    mem_req_t           ahb_data;
    logic               ahb_ack;
    mem_resp_e          ahb_resp;
    logic [XLEN-1:0]    ahb_rdata;

    dmem_router #(
        .TCM_ADDR_MASK      (TCM_ADDR_MASK),
        .TCM_ADDR_PATTERN   (TCM_ADDR_PATTERN),
        .TIMER_ADDR_MASK    (TIMER_ADDR_MASK),
        .TIMER_ADDR_PATTERN (TIMER_ADDR_PATTERN)
    ) u_router (
        .clk          (clk),
        .rst_i        (rst_i),
        .req_i        (req_i),
        .req_data_i   (req_data_i),
        .req_ack_o    (req_ack_o),
        .resp_o       (resp_o),
        .rdata_o      (rdata_o),
        .tcm_req_o    (tcm_req),
        .tcm_data_o   (tcm_data),
        .tcm_ack_i    (tcm_ack),
        .tcm_resp_i   (tcm_resp),
        .tcm_rdata_i  (tcm_rdata),
        .tmr_req_o    (tmr_req),
        .tmr_data_o   (tmr_data),
        .tmr_ack_i    (tmr_ack),
        .tmr_resp_i   (tmr_resp),
        .tmr_rdata_i  (tmr_rdata),
        .ahb_req_o    (ahb_req),
        .ahb_data_o   (ahb_data),
        .ahb_ack_i    (ahb_ack),
        .ahb_resp_i   (ahb_resp),
        .ahb_rdata_i  (ahb_rdata)
    );

    dmem_tcm #(
        .TCM_WORDS (TCM_WORDS)
    ) u_tcm (
        .clk        (clk),
        .rst_i      (rst_i),
        .req_i      (tcm_req),
        .req_data_i (tcm_data),
        .req_ack_o  (tcm_ack),
        .resp_o     (tcm_resp),
        .rdata_o    (tcm_rdata)
    );

    mtimer u_timer (
        .clk         (clk),
        .rst_i       (rst_i),
        .req_i       (tmr_req),
        .req_data_i  (tmr_data),
        .req_ack_o   (tmr_ack),
        .resp_o      (tmr_resp),
        .rdata_o     (tmr_rdata),
        .timer_irq_o (timer_irq_o)
    );

    dmem_ahb_bridge u_ahb (
        .clk        (clk),
        .rst_i      (rst_i),
        .req_i      (ahb_req),
        .req_data_i (ahb_data),
        .req_ack_o  (ahb_ack),
        .resp_o     (ahb_resp),
        .rdata_o    (ahb_rdata),
        .ahb_o      (ahb_o),
        .ahb_i      (ahb_i)
    );

endmodule : dmem_subsys_top

/* tests/tb_dmem_subsys.sv */
//----------------------------------------
// Testbench of the data-memory subsystem:
// trace reader, AHB memory slave model,
// checks and report
//----------------------------------------

module tb_dmem_subsys;
    timeunit 1ns;
    timeprecision 1ps;

    import dmem_pkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int LINE_CYCLES  = 40;   // Worst-case wait states plus margin
    localparam int STEP_LIMIT   = 40;

    logic               clk = 1'b0;
    logic               rst_i;
    logic               req_i;
    mem_req_t           req_data_i;
    logic               req_ack_o;
    mem_resp_e          resp_o;
    logic [XLEN-1:0]    rdata_o;
    ahb_m2s_t           ahb_o;
    ahb_s2m_t           ahb_i;
    logic               timer_irq_o;

    // Trace columns
    string              name_q[$];
    string              cmd_q[$];
    string              width_q[$];
    logic [31:0]        addr_q[$];
    logic [31:0]        wdata_q[$];
    string              resp_tok_q[$];
    string              rdata_tok_q[$];

    int                 cycle_cnt   = 0;
    int                 cycle_limit = 1000000;
    int                 n_pass      = 0;
    int                 n_fail      = 0;
    logic [31:0]        last_rdata  = '0;   // Previous good read, for gt and eq

    // AHB slave model
    logic [31:0]        ahb_mem [256];
    logic [1:0]         wait_tbl [64];      // Wait states, one per transfer
    int                 wait_idx  = 0;
    logic               dp_active = 1'b0;
    logic [31:0]        dp_addr   = '0;
    logic               dp_write  = 1'b0;
    logic [2:0]         dp_size   = '0;
    logic [1:0]         dp_wait   = '0;
    logic [2:0]         exp_hsize;
    logic               exp_hwrite;
    logic               phase_bad;
    logic [2:0]         bad_hsize;
    logic               bad_hwrite;

    always #4 clk = ~clk;

    dmem_subsys_top u_dut (
        .clk         (clk),
        .rst_i       (rst_i),
        .req_i       (req_i),
        .req_data_i  (req_data_i),
        .req_ack_o   (req_ack_o),
        .resp_o      (resp_o),
        .rdata_o     (rdata_o),
        .ahb_o       (ahb_o),
        .ahb_i       (ahb_i),
        .timer_irq_o (timer_irq_o)
    );

    function automatic logic [3:0] lane_mask(input logic [2:0] size, input logic [1:0] a);
        case (size)
            3'd0:    return 4'b0001 << a;
            3'd1:    return 4'b0011 << {a[1], 1'b0};
            default: return 4'b1111;
        endcase
    endfunction

    function automatic mem_width_e width_of(input string w);
        if (w == "b") return MEM_WIDTH_BYTE;
        if (w == "h") return MEM_WIDTH_HWORD;
        return MEM_WIDTH_WORD;
    endfunction

    //----------------------------------------
    // AHB slave, error window at 8000_0000
    //----------------------------------------
    always_comb begin
        ahb_i.hready = !dp_active || (dp_wait == 2'd0);
        ahb_i.hresp  = dp_active && (dp_addr[31:24] == 8'h80);
        ahb_i.hrdata = dp_active ? ahb_mem[dp_addr[9:2]] : '0;
    end

    always @(posedge clk) begin
        logic [3:0]  mask;
        mask = lane_mask(dp_size, dp_addr[1:0]);
        if (rst_i) begin
            dp_active <= 1'b0;
            dp_wait   <= 2'd0;
        end else begin
            if (dp_active && ahb_i.hready) begin        // Data phase ends
                dp_active <= 1'b0;
                if (dp_write && !ahb_i.hresp) begin
                    for (int i = 0; i < 4; i++) begin
                        if (mask[i]) begin
                            ahb_mem[dp_addr[9:2]][8*i +: 8] <= ahb_o.hwdata[8*i +: 8];
                        end
                    end
                end
            end else if (dp_active) begin
                dp_wait <= dp_wait - 2'd1;
            end
            if (ahb_o.htrans == HTRANS_NONSEQ && ahb_i.hready) begin
                dp_active <= 1'b1;
                dp_addr   <= ahb_o.haddr;
                dp_write  <= ahb_o.hwrite;
                dp_size   <= ahb_o.hsize;
                dp_wait   <= wait_tbl[wait_idx[5:0]];
                wait_idx  <= wait_idx + 1;
                if (ahb_o.hsize != exp_hsize || ahb_o.hwrite != exp_hwrite) begin
                    phase_bad  <= 1'b1;
                    bad_hsize  <= ahb_o.hsize;
                    bad_hwrite <= ahb_o.hwrite;
                end
            end
        end
    end

    // Run limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("Run stopped after %0d cycles with the trace unfinished", cycle_cnt);
            $display("Finished with errors");
            $finish;
        end
    end

    task automatic tally(input string name, input logic bad);
        if (bad) begin
            n_fail++;
        end else begin
            n_pass++;
            $display("[PASS] %s", name);
        end
    endtask

    task automatic load_trace();
        int          fd;
        int          c;
        string       tok;
        string       cmd_s;
        string       width_s;
        string       resp_s;
        string       rdata_s;
        logic [31:0] a;
        logic [31:0] d;
        fd = $fopen("tests/dmem_trace.txt", "r");
        if (fd == 0) begin
            $display("Trace file tests/dmem_trace.txt could not be opened");
            n_fail++;
            return;
        end
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok[0] == "#") begin
                c = $fgetc(fd);
                while (c != "\n" && c != -1) begin
                    c = $fgetc(fd);
                end
            end else if ($fscanf(fd, "%s %s %h %h %s %s", cmd_s, width_s, a, d,
                                 resp_s, rdata_s) != 6) begin
                $display("Trace line for %s is incomplete", tok);
                n_fail++;
            end else begin
                name_q.push_back(tok);
                cmd_q.push_back(cmd_s);
                width_q.push_back(width_s);
                addr_q.push_back(a);
                wdata_q.push_back(d);
                resp_tok_q.push_back(resp_s);
                rdata_tok_q.push_back(rdata_s);
            end
        end
        $fclose(fd);
    endtask

    task automatic check_reset_state();
        mem_resp_e idle_resp;
        logic      bad;
        idle_resp = MEM_RESP_IDLE;
        bad       = 1'b0;
        if (resp_o !== idle_resp) begin
            $display("[FAIL] after_reset: resp_o expected %s actual %s",
                     idle_resp.name(), resp_o.name());
            bad = 1'b1;
        end
        if (ahb_o.htrans !== HTRANS_IDLE) begin
            $display("[FAIL] after_reset: htrans expected %b actual %b",
                     HTRANS_IDLE, ahb_o.htrans);
            bad = 1'b1;
        end
        if (timer_irq_o !== 1'b0) begin
            $display("[FAIL] after_reset: timer_irq_o expected 0 actual %b", timer_irq_o);
            bad = 1'b1;
        end
        tally("after_reset", bad);
    endtask

    //----------------------------------------
    // One trace access
    //----------------------------------------
    task automatic run_access(input int k);
        mem_req_t   r;
        mem_resp_e  exp_resp;
        logic [31:0] exp_data;
        string      tok;
        int         n;
        logic       done;
        logic       bad;
        r.cmd      = (cmd_q[k] == "wr") ? MEM_CMD_WR : MEM_CMD_RD;
        r.width    = width_of(width_q[k]);
        r.addr     = addr_q[k];
        r.wdata    = wdata_q[k];
        exp_resp   = (resp_tok_q[k] == "ok") ? MEM_RESP_RDY_OK : MEM_RESP_RDY_ER;
        tok        = rdata_tok_q[k];
        exp_hsize  = (width_q[k] == "b") ? 3'd0 : (width_q[k] == "h") ? 3'd1 : 3'd2;
        exp_hwrite = (cmd_q[k] == "wr");
        phase_bad  = 1'b0;
        bad        = 1'b0;
        @(posedge clk);
        req_i      <= 1'b1;
        req_data_i <= r;
        done = 1'b0;
        n    = 0;
        while (!done && n < STEP_LIMIT) begin
            @(negedge clk);
            done = req_ack_o;
            n++;
        end
        @(posedge clk);
        req_i <= 1'b0;
        if (!done) begin
            $display("%s: request was not acknowledged within %0d cycles", name_q[k], n);
            tally(name_q[k], 1'b1);
            return;
        end
        done = 1'b0;
        n    = 0;
        while (!done && n < STEP_LIMIT) begin
            @(negedge clk);
            done = (resp_o != MEM_RESP_IDLE);
            n++;
        end
        if (!done) begin
            $display("%s: no response arrived within %0d cycles", name_q[k], n);
            bad = 1'b1;
        end else if (resp_o != exp_resp) begin
            $display("[FAIL] %s: resp expected %s actual %s", name_q[k], exp_resp.name(),
                     resp_o.name());
            bad = 1'b1;
        end else if (phase_bad) begin
            $display("[FAIL] %s: hsize/hwrite expected %0d/%b actual %0d/%b", name_q[k],
                     exp_hsize, exp_hwrite, bad_hsize, bad_hwrite);
            bad = 1'b1;
        end else if (exp_resp == MEM_RESP_RDY_OK && r.cmd == MEM_CMD_RD) begin
            if (tok == "gt") begin
                if (!(rdata_o > last_rdata)) begin
                    $display("[FAIL] %s: expected above %h actual %h", name_q[k],
                             last_rdata, rdata_o);
                    bad = 1'b1;
                end
            end else if (tok == "eq") begin
                if (rdata_o != last_rdata) begin
                    $display("[FAIL] %s: expected %h actual %h", name_q[k], last_rdata, rdata_o);
                    bad = 1'b1;
                end
            end else if (tok != "skip") begin
                void'($sscanf(tok, "%h", exp_data));
                if (rdata_o !== exp_data) begin
                    $display("[FAIL] %s: expected %h actual %h", name_q[k], exp_data, rdata_o);
                    bad = 1'b1;
                end
            end
            last_rdata = rdata_o;
        end
        tally(name_q[k], bad);
    endtask

    // Irq level must show up within 3 cycles
    task automatic check_irq(input int k);
        logic exp_lvl;
        logic seen;
        int   n;
        exp_lvl = (rdata_tok_q[k] == "1");
        seen    = (timer_irq_o === exp_lvl);
        n       = 0;
        while (!seen && n < 3) begin
            @(negedge clk);
            seen = (timer_irq_o === exp_lvl);
            n++;
        end
        if (!seen) begin
            $display("[FAIL] %s: timer_irq_o expected %b actual %b", name_q[k], exp_lvl,
                     timer_irq_o);
        end
        tally(name_q[k], !seen);
    endtask

    initial begin
        int unsigned draw;
        rst_i      = 1'b1;
        req_i      = 1'b0;
        req_data_i = '0;
        exp_hsize  = 3'd0;
        exp_hwrite = 1'b0;
        phase_bad  = 1'b0;
        // Wait states come from the one seeded stream
        draw        = $urandom(32'h800f);
        wait_tbl[0] = draw[1:0];
        for (int i = 1; i < 64; i++) begin
            draw        = $urandom;
            wait_tbl[i] = draw[1:0];
        end
        for (int i = 0; i < 256; i++) begin
            ahb_mem[i] = '0;
        end
        load_trace();
        cycle_limit = name_q.size() * LINE_CYCLES + RESET_CYCLES;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_i <= 1'b0;
        @(negedge clk);
        check_reset_state();
        for (int k = 0; k < name_q.size(); k++) begin
            if (cmd_q[k] == "irq") begin
                check_irq(k);
            end else begin
                run_access(k);
            end
        end
        $display("Tests passed: %0d, failed: %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule : tb_dmem_subsys

/* tests/dmem_trace.txt */
# name cmd(rd/wr/irq) width(b/h/w) addr wdata resp(ok/er) rdata(hex, skip, gt, eq)
# gt and eq compare with the previous good read; irq lines give the expected level
tcm_wr_word      wr  w 00000100 11223344 ok skip
tcm_wr_byte      wr  b 00000101 0000aa00 ok skip
tcm_wr_half      wr  h 00000102 beef0000 ok skip
tcm_rd_merged    rd  w 00000100 00000000 ok beefaa44
tcm_rd_misalign  rd  w 00000102 00000000 er skip
tcm_wr_word2     wr  w 00000104 55667788 ok skip
tcm_wr_misalign  wr  h 00000105 ffffffff er skip
tcm_rd_intact    rd  w 00000104 00000000 ok 55667788
ahb_wr_word      wr  w 10000000 cafef00d ok skip
ahb_rd_word      rd  w 10000000 00000000 ok cafef00d
ahb_wr_byte      wr  b 10000005 00005a00 ok skip
ahb_wr_half      wr  h 10000006 12340000 ok skip
ahb_rd_byte      rd  b 10000005 00000000 ok 12345a00
ahb_rd_half      rd  h 10000006 00000000 ok 12345a00
ahb_rd_word2     rd  w 10000004 00000000 ok 12345a00
ahb_err_rd       rd  w 80000010 00000000 er skip
ahb_err_wr       wr  w 80000020 deadbeef er skip
ahb_rd_after_err rd  w 10000000 00000000 ok cafef00d
tmr_rd_time1     rd  w 00490004 00000000 ok skip
tmr_rd_time2     rd  w 00490004 00000000 ok gt
tmr_cmp_lo_zero  wr  w 0049000c 00000000 ok skip
tmr_cmp_hi_zero  wr  w 00490010 00000000 ok skip
tmr_irq_high     irq w 00000000 00000000 ok 1
tmr_cmp_hi_ones  wr  w 00490010 ffffffff ok skip
tmr_irq_low      irq w 00000000 00000000 ok 0
tmr_byte_access  rd  b 00490004 00000000 er skip
tmr_bad_offset   rd  w 00490014 00000000 er skip
tmr_stop         wr  w 00490000 00000000 ok skip
tmr_rd_stop1     rd  w 00490004 00000000 ok skip
tmr_rd_stop2     rd  w 00490004 00000000 ok eq

/* verilog.f */
logic/dmem_pkg.sv
logic/dmem_router.sv
logic/dmem_tcm.sv
logic/mtimer.sv
logic/dmem_ahb_bridge.sv
logic/dmem_subsys_top.sv
tests/tb_dmem_subsys.sv

/* Bender.yml */
package:
  name: dmem_subsys

sources:
  # Package first, then the blocks, then the top level
  - logic/dmem_pkg.sv
  - logic/dmem_router.sv
  - logic/dmem_tcm.sv
  - logic/mtimer.sv
  - logic/dmem_ahb_bridge.sv
  - logic/dmem_subsys_top.sv

  - target: test
    files:
      - tests/tb_dmem_subsys.sv
